// ==== hw/arcade_input_pkg.sv ====
/*
 * Shared widths, PS/2 key codes, the mahjong quirk code and the board
 * configuration types for the arcade input path. Modules pull these in
 * with a wildcard import in their header.
 */
package arcade_input_pkg;

	localparam int port_w  = 8;  // One game input port
	localparam int joy_w   = 16; // Host joystick word
	localparam int rgb_w   = 12; // 4 bits per channel
	localparam int mj_rows = 7;
	localparam int mj_cols = 5;

	localparam logic [7:0] quirk_dakkochan = 8'h01; // Mode byte 1 value for mahjong
	localparam logic [7:0] cfg_index_mode  = 8'd1;
	localparam logic [7:0] cfg_index_dsw   = 8'd254;

	typedef enum logic [1:0] {
		mode_standard   = 2'd0,
		mode_dual_stick = 2'd1,
		mode_mahjong    = 2'd2
	} input_mode_t;

	typedef struct packed {
		input_mode_t mode;
		logic        button_swap;
		logic [7:0]  dsw0;
		logic [7:0]  dsw1;
	} board_cfg_t;

	typedef logic [mj_rows-1:0][mj_cols-1:0] mj_matrix_t; // [row][col]

	////////////////////////////////////////
	// PS/2 set 2 codes, bit 8 is the E0 prefix

	localparam logic [8:0] key_code_start1  = 9'h016; // 1
	localparam logic [8:0] key_code_start2  = 9'h01e; // 2
	localparam logic [8:0] key_code_coin1   = 9'h02e; // 5
	localparam logic [8:0] key_code_coin2   = 9'h036; // 6
	localparam logic [8:0] key_code_test    = 9'h006; // F2
	localparam logic [8:0] key_code_reset   = 9'h004; // F3
	localparam logic [8:0] key_code_service = 9'h046; // 9

	// Mahjong panel
	localparam logic [8:0] key_code_mj_kan   = 9'h014; // Left ctrl
	localparam logic [8:0] key_code_mj_reach = 9'h012; // Left shift
	localparam logic [8:0] key_code_mj_ron   = 9'h01a; // z
	localparam logic [8:0] key_code_mj_t     = 9'h02c;
	localparam logic [8:0] key_code_mj_u     = 9'h03c;
	localparam logic [8:0] key_code_mj_o     = 9'h044;
	localparam logic [8:0] key_code_mj_p     = 9'h04d;
	localparam logic [8:0] key_code_mj_a     = 9'h01c;
	localparam logic [8:0] key_code_mj_b     = 9'h032;
	localparam logic [8:0] key_code_mj_c     = 9'h021;
	localparam logic [8:0] key_code_mj_d     = 9'h023;
	localparam logic [8:0] key_code_mj_last  = 9'h111; // Right alt, last chance
	localparam logic [8:0] key_code_mj_e     = 9'h024;
	localparam logic [8:0] key_code_mj_f     = 9'h02b;
	localparam logic [8:0] key_code_mj_g     = 9'h034;
	localparam logic [8:0] key_code_mj_h     = 9'h033;
	localparam logic [8:0] key_code_mj_i     = 9'h043;
	localparam logic [8:0] key_code_mj_j     = 9'h03b;
	localparam logic [8:0] key_code_mj_k     = 9'h042;
	localparam logic [8:0] key_code_mj_l     = 9'h04b;
	localparam logic [8:0] key_code_mj_m     = 9'h03a;
	localparam logic [8:0] key_code_mj_n     = 9'h031;
	localparam logic [8:0] key_code_mj_chi   = 9'h029; // Space
	localparam logic [8:0] key_code_mj_pon   = 9'h011; // Left alt
	localparam logic [8:0] key_code_mj_flip  = 9'h035; // y, flip-flop
	localparam logic [8:0] key_code_mj_bet   = 9'h026; // 3

endpackage

// ==== hw/arcade_inputs_top.sv ====
/*
 * Top of the arcade input and pause path. Host writes, PS/2 events and
 * joysticks enter as plain ports; the three game input ports, DIP bytes,
 * pause and the dimmed video colour leave the same way.
 */
`timescale 1ns/1ps

module arcade_inputs_top import arcade_input_pkg::*; #(
	parameter logic [31:0] DIM_DELAY = 32'd400_000_000
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              ioctl_wr,
	input  logic [7:0]        ioctl_index,
	input  logic [24:0]       ioctl_addr,
	input  logic [7:0]        ioctl_dout,
	input  logic [10:0]       ps2_key,
	input  logic [joy_w-1:0]  joy1,
	input  logic [joy_w-1:0]  joy2,
	input  logic              svc_sw,
	input  logic              test_sw,
	input  logic              osd_open,
	input  logic              pause_on_osd,
	input  logic              mux_clock,
	input  logic [rgb_w-1:0]  rgb_in,
	output logic [port_w-1:0] inp0,
	output logic [port_w-1:0] inp1,
	output logic [port_w-1:0] inp2,
	output logic [7:0]        dsw0,
	output logic [7:0]        dsw1,
	output logic              pause,
	output logic [rgb_w-1:0]  rgb_out
);

	board_cfg_t cfg;
	key_if      key_bus ();
	ctrl_if     ctrl_bus ();

	assign dsw0 = cfg.dsw0;
	assign dsw1 = cfg.dsw1;

	////////////////////////////////////////
	// Input pipeline

	host_config_loader u_loader (.clk_sys, .rst_n, .ioctl_wr, .ioctl_index,
		.ioctl_addr, .ioctl_dout, .cfg);

	ps2_key_decoder u_keys (.clk_sys, .rst_n, .ps2_key, .keys(key_bus.source));

	control_merge u_merge (
		.clk_sys,
		.rst_n,
		.joy1,
		.joy2,
		.svc_sw,
		.test_sw,
		.keys(key_bus.sink),
		.ctrl(ctrl_bus.source)
	);

	input_port_mux u_ports (
		.clk_sys,
		.rst_n,
		.cfg,
		.mux_clock,
		.ctrl(ctrl_bus.sink),
		.keys(key_bus.mj_sink),
		.inp0,
		.inp1,
		.inp2
	);

	pause_dimmer #(.DIM_DELAY(DIM_DELAY)) u_pause (.clk_sys, .rst_n, .osd_open, .pause_on_osd,
		.rgb_in, .ctrl(ctrl_bus.sink), .pause, .rgb_out);

endmodule

// ==== hw/control_merge.sv ====
/*
 * Stage 3. Folds both joysticks, the keyboard states and the service and
 * test switches into one registered set of player controls.
 */
`timescale 1ns/1ps

module control_merge import arcade_input_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [joy_w-1:0] joy1,
	input  logic [joy_w-1:0] joy2,
	input  logic             svc_sw,
	input  logic             test_sw,
	key_if.sink              keys,
	ctrl_if.source           ctrl
);

	logic [joy_w-1:0] joy; // Either player drives the shared controls

	assign joy = joy1 | joy2;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl.up        <= 1'b0;
			ctrl.down      <= 1'b0;
			ctrl.left      <= 1'b0;
			ctrl.right     <= 1'b0;
			ctrl.lstick    <= '0;
			ctrl.rstick    <= '0;
			ctrl.trig      <= '0;
			ctrl.start1    <= 1'b0;
			ctrl.start2    <= 1'b0;
			ctrl.coin1     <= 1'b0;
			ctrl.coin2     <= 1'b0;
			ctrl.service   <= 1'b0;
			ctrl.test      <= 1'b0;
			ctrl.pause_btn <= 1'b0;
		end else begin
			ctrl.up     <= joy[3];
			ctrl.down   <= joy[2];
			ctrl.left   <= joy[1];
			ctrl.right  <= joy[0];
			ctrl.lstick <= joy1[3:0];
			ctrl.rstick <= joy1[7:4] | joy2[3:0]; // Second stick of pad 1 or pad 2
			ctrl.trig   <= joy[6:4];
			// Player 2 start sits at the mirrored button
			ctrl.start1    <= joy1[9] | joy2[10] | keys.start1;
			ctrl.start2    <= joy1[10] | joy2[9] | keys.start2;
			ctrl.coin1     <= joy1[11] | keys.coin1;
			ctrl.coin2     <= joy2[11] | keys.coin2;
			ctrl.service   <= keys.service | svc_sw;
			ctrl.test      <= keys.test | test_sw;
			ctrl.pause_btn <= joy[12];
		end
	end

endmodule

// ==== hw/host_config_loader.sv ====
/*
 * Stage 1. Captures the system-mode bytes and DIP-switch bytes from host
 * download writes and decodes the input layout from them.
 */
`timescale 1ns/1ps

module host_config_loader import arcade_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output board_cfg_t  cfg
);

	logic [7:0] sys_mode0; // [3] dual stick, [7] button swap
	logic [7:0] sys_mode1; // Quirk byte
	logic [7:0] dsw0_q;
	logic [7:0] dsw1_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sys_mode0 <= '0;
			sys_mode1 <= '0;
			dsw0_q    <= '0;
			dsw1_q    <= '0;
		end else if (ioctl_wr) begin
			// Mode bytes 2 and 3 exist on the host side but carry nothing here
			if (ioctl_index == cfg_index_mode && ioctl_addr[24:1] == '0) begin
				if (ioctl_addr[0]) sys_mode1 <= ioctl_dout;
				else sys_mode0 <= ioctl_dout;
			end
			if (ioctl_index == cfg_index_dsw && ioctl_addr[24:1] == '0) begin
				if (ioctl_addr[0]) dsw1_q <= ioctl_dout;
				else dsw0_q <= ioctl_dout;
			end
		end
	end

	// Dual stick wins over the mahjong quirk
	assign cfg.mode = sys_mode0[3] ? mode_dual_stick :
		(sys_mode1 == quirk_dakkochan) ? mode_mahjong : mode_standard;
	assign cfg.button_swap = sys_mode0[7];
	assign cfg.dsw0        = dsw0_q;
	assign cfg.dsw1        = dsw1_q;

	a_mode_legal: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cfg.mode inside {mode_standard, mode_dual_stick, mode_mahjong});

endmodule

// ==== hw/input_ifs.sv ====
/*
 * Bundles between the input stages. key_if carries held key states from
 * the PS/2 decoder, ctrl_if the merged player controls from the merge stage.
 */
`timescale 1ns/1ps

interface key_if import arcade_input_pkg::*;;
	logic       start1;
	logic       start2;
	logic       coin1;
	logic       coin2;
	logic       test;
	logic       service;
	logic       reset_key;
	mj_matrix_t mj;

	modport source (output start1, start2, coin1, coin2, test, service, reset_key, mj);
	modport sink (input start1, start2, coin1, coin2, test, service, reset_key);
	modport mj_sink (input mj); // Matrix only, for the port scanner
endinterface

interface ctrl_if;
	logic       up;
	logic       down;
	logic       left;
	logic       right;
	logic [3:0] lstick; // {up, down, left, right}
	logic [3:0] rstick;
	logic [2:0] trig;   // Buttons 1 to 3 at bits 0 to 2
	logic       start1;
	logic       start2;
	logic       coin1;
	logic       coin2;
	logic       service;
	logic       test;
	logic       pause_btn;

	modport source (output up, down, left, right, lstick, rstick, trig,
		start1, start2, coin1, coin2, service, test, pause_btn);
	modport sink (input up, down, left, right, lstick, rstick, trig,
		start1, start2, coin1, coin2, service, test, pause_btn);
endinterface

// ==== hw/input_port_mux.sv ====
/*
 * Stage 4. Packs the player controls into the three active-low ports the
 * game reads, in the standard, dual-stick or mahjong layout. For mahjong
 * the key matrix is scanned one row per rising edge of mux_clock.
 */
`timescale 1ns/1ps

module input_port_mux import arcade_input_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  board_cfg_t        cfg,
	input  logic              mux_clock,
	ctrl_if.sink              ctrl,
	key_if.mj_sink            keys,
	output logic [port_w-1:0] inp0,
	output logic [port_w-1:0] inp1,
	output logic [port_w-1:0] inp2
);

	localparam int row_w = $clog2(mj_rows);

	logic               mux_clock_q;
	logic               mux_rise;
	logic [row_w-1:0]   row_cnt;
	logic [row_w-1:0]   row_nxt;
	logic [mj_rows-1:0] row_sel;
	logic [mj_rows-1:0] sel_nxt;
	mj_matrix_t         mj_eff;
	logic [mj_cols-1:0] row_keys;
	logic [2:0]         trig_ord;
	logic [port_w-1:0]  p0_nxt;
	logic [port_w-1:0]  p1_nxt;
	logic [port_w-1:0]  p2_nxt;

	assign mux_rise = mux_clock & ~mux_clock_q;

	////////////////////////////////////////
	// Mahjong row scan

	always_comb begin
		row_nxt = row_cnt;
		sel_nxt = row_sel;
		if (mux_rise) begin
			row_nxt = (row_cnt == row_w'(mj_rows - 1)) ? '0 : row_cnt + 1'b1;
			sel_nxt = {row_sel[mj_rows-2:0], row_sel[mj_rows-1]}; // Rotate left
		end
	end

	always_comb begin
		mj_eff = keys.mj;
		mj_eff[mj_rows-1][0] = ctrl.start1 | ctrl.start2; // Either start on row 6
	end

	assign row_keys = mj_eff[row_nxt]; // New row shows on the same edge
	assign trig_ord = cfg.button_swap ? {ctrl.trig[2], ctrl.trig[0], ctrl.trig[1]} : ctrl.trig;

	////////////////////////////////////////
	// Port layouts

	always_comb begin
		case (cfg.mode)
			mode_dual_stick: begin
				p0_nxt = ~{ctrl.lstick[1], ctrl.lstick[0], ctrl.lstick[3], ctrl.lstick[2],
					ctrl.rstick[1], ctrl.rstick[0], ctrl.rstick[3], ctrl.rstick[2]};
				p1_nxt = p0_nxt;
				p2_nxt = ~{ctrl.trig[0], ctrl.trig[0], ctrl.start2, ctrl.start1,
					2'b00, ctrl.coin2, ctrl.coin1};
			end
			mode_mahjong: begin
				p0_nxt = {{(port_w - mj_cols){1'b1}}, ~row_keys};
				p1_nxt = {{(port_w - mj_rows){1'b0}}, sel_nxt}; // Active high select
				p2_nxt = ~{ctrl.trig[0], ctrl.trig[0], 2'b00, ctrl.service, ctrl.test,
					ctrl.coin2, ctrl.coin1};
			end
			default: begin
				p0_nxt = ~{ctrl.left, ctrl.right, ctrl.up, ctrl.down, 1'b0, trig_ord};
				p1_nxt = p0_nxt;
				p2_nxt = ~{2'b00, ctrl.start2, ctrl.start1, ctrl.service, ctrl.test,
					ctrl.coin2, ctrl.coin1};
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mux_clock_q <= 1'b0;
			row_cnt     <= '0;
			row_sel     <= mj_rows'(1);
			inp0        <= '1;
			inp1        <= '1;
			inp2        <= '1;
		end else begin
			mux_clock_q <= mux_clock;
			row_cnt     <= row_nxt;
			row_sel     <= sel_nxt;
			inp0        <= p0_nxt;
			inp1        <= p1_nxt;
			inp2        <= p2_nxt;
		end
	end

	// Select and row count must stay locked together
	a_row_sel: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot(row_sel) && row_sel == (mj_rows'(1) << row_cnt));

endmodule

// ==== hw/pause_dimmer.sv ====
/*
 * Pause control. The pause button toggles pause, an open OSD pauses when
 * the option is set, and after DIM_DELAY cycles of toggled pause the video
 * colour is halved per channel.
 */
`timescale 1ns/1ps

module pause_dimmer import arcade_input_pkg::*; #(
	parameter logic [31:0] DIM_DELAY = 32'd400_000_000 // 10 s at 40 MHz
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             osd_open,
	input  logic             pause_on_osd,
	input  logic [rgb_w-1:0] rgb_in,
	ctrl_if.sink             ctrl,
	output logic             pause,
	output logic [rgb_w-1:0] rgb_out
);

	logic        btn_q;
	logic        btn_rise;
	logic        pause_toggle;
	logic        toggle_nxt;
	logic [31:0] dim_cnt;
	logic        dim;

	assign btn_rise   = ctrl.pause_btn & ~btn_q;
	assign toggle_nxt = pause_toggle ^ btn_rise;
	assign dim        = (dim_cnt == DIM_DELAY);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn_q        <= 1'b0;
			pause_toggle <= 1'b0;
			pause        <= 1'b0;
			dim_cnt      <= '0;
		end else begin
			btn_q        <= ctrl.pause_btn;
			pause_toggle <= toggle_nxt;
			pause        <= toggle_nxt | (osd_open & pause_on_osd);
			if (!pause_toggle) dim_cnt <= '0;
			else if (!dim) dim_cnt <= dim_cnt + 1'b1; // Holds at DIM_DELAY
		end
	end

	// Each 4-bit channel shifted right by one
	always_ff @(posedge clk_sys) begin
		rgb_out <= dim ? {1'b0, rgb_in[11:9], 1'b0, rgb_in[7:5], 1'b0, rgb_in[3:1]} : rgb_in;
	end

	a_dim_bound: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dim_cnt <= DIM_DELAY);

endmodule

// ==== hw/ps2_key_decoder.sv ====
/*
 * Stage 2. Watches the PS/2 event toggle bit and keeps a held state for
 * every key the board knows. Codes it does not know are dropped.
 */
`timescale 1ns/1ps

module ps2_key_decoder import arcade_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	key_if.source       keys
);

	logic       toggle_q;
	logic       event_seen;
	logic       pressed;
	logic [8:0] code;

	assign event_seen = (ps2_key[10] != toggle_q);
	assign pressed    = ps2_key[9];
	assign code       = ps2_key[8:0];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q       <= ps2_key[10]; // No stale event out of reset
			keys.start1    <= 1'b0;
			keys.start2    <= 1'b0;
			keys.coin1     <= 1'b0;
			keys.coin2     <= 1'b0;
			keys.test      <= 1'b0;
			keys.service   <= 1'b0;
			keys.reset_key <= 1'b0;
			keys.mj        <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (event_seen) begin
				case (code)
					key_code_start1:  keys.start1    <= pressed;
					key_code_start2:  keys.start2    <= pressed;
					key_code_coin1:   keys.coin1     <= pressed;
					key_code_coin2:   keys.coin2     <= pressed;
					key_code_test:    keys.test      <= pressed;
					key_code_reset:   keys.reset_key <= pressed;
					key_code_service: keys.service   <= pressed;
					// Row 0
					key_code_mj_kan:   keys.mj[0][0] <= pressed;
					key_code_mj_reach: keys.mj[0][1] <= pressed;
					key_code_mj_ron:   keys.mj[0][2] <= pressed;
					// Row 1
					key_code_mj_t: keys.mj[1][0] <= pressed;
					key_code_mj_u: keys.mj[1][1] <= pressed;
					key_code_mj_o: keys.mj[1][2] <= pressed;
					key_code_mj_p: keys.mj[1][3] <= pressed;
					// Row 2
					key_code_mj_a:    keys.mj[2][0] <= pressed;
					key_code_mj_b:    keys.mj[2][1] <= pressed;
					key_code_mj_c:    keys.mj[2][2] <= pressed;
					key_code_mj_d:    keys.mj[2][3] <= pressed;
					key_code_mj_last: keys.mj[2][4] <= pressed;
					// Rows 3 and 4
					key_code_mj_e: keys.mj[3][0] <= pressed;
					key_code_mj_f: keys.mj[3][1] <= pressed;
					key_code_mj_g: keys.mj[3][2] <= pressed;
					key_code_mj_h: keys.mj[3][3] <= pressed;
					key_code_mj_i: keys.mj[4][0] <= pressed;
					key_code_mj_j: keys.mj[4][1] <= pressed;
					key_code_mj_k: keys.mj[4][2] <= pressed;
					key_code_mj_l: keys.mj[4][3] <= pressed;
					// Row 5
					key_code_mj_m:    keys.mj[5][0] <= pressed;
					key_code_mj_n:    keys.mj[5][1] <= pressed;
					key_code_mj_chi:  keys.mj[5][2] <= pressed;
					key_code_mj_pon:  keys.mj[5][3] <= pressed;
					key_code_mj_flip: keys.mj[5][4] <= pressed;
					// Row 6, bit 0 is filled from the start buttons later
					key_code_mj_bet: keys.mj[6][1] <= pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the arcade input testbench with Verilator and run it.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module arcade_inputs_tb -Mdir obj_dir -o arcade_inputs_sim -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/arcade_inputs_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
exit 1

// ==== test/arcade_inputs_tb.sv ====
/*
 * Testbench for the arcade input path. Runs six randomized tests on the
 * DUT while input_checker models and compares it every cycle.
 * Build and run it with run_sim.sh.
 */
`timescale 1ns/1ps

module arcade_inputs_tb import arcade_input_pkg::*; ();

	localparam logic [31:0] DIM_DELAY = 32'd200;
	localparam int clk_period = 40;
	localparam int n_cfg   = 200;
	localparam int n_std   = 300;
	localparam int n_ps2   = 150;
	localparam int n_dual  = 200;
	localparam int n_mj    = 400;
	localparam int n_pause = 300;
	localparam int hold_cycles = int'(DIM_DELAY) + 60; // Long enough to see the dim
	// Worst case per test, layout writes included
	localparam int test_cycles = 2 * n_cfg + n_std + 4 * n_ps2 + n_dual + n_mj + n_pause
		+ 2 * (hold_cycles + 2) + 40;
	localparam int timeout_cycles = test_cycles + int'(DIM_DELAY) + 500;

	logic              clk_sys;
	logic              rst_n;
	logic              ioctl_wr;
	logic [7:0]        ioctl_index;
	logic [24:0]       ioctl_addr;
	logic [7:0]        ioctl_dout;
	logic [10:0]       ps2_key;
	logic [joy_w-1:0]  joy1;
	logic [joy_w-1:0]  joy2;
	logic              svc_sw;
	logic              test_sw;
	logic              osd_open;
	logic              pause_on_osd;
	logic              mux_clock;
	logic [rgb_w-1:0]  rgb_in;
	logic [port_w-1:0] inp0;
	logic [port_w-1:0] inp1;
	logic [port_w-1:0] inp2;
	logic [7:0]        dsw0;
	logic [7:0]        dsw1;
	logic              pause;
	logic [rgb_w-1:0]  rgb_out;
	int                test_num;
	int                err_count;
	integer            seed = 32'ha868;
	logic [31:0]       rnd;

	arcade_inputs_top #(.DIM_DELAY(DIM_DELAY)) arcade_inputs_top_i (.*);

	input_checker #(.DIM_DELAY(DIM_DELAY)) scoreboard (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// Watchdog
	initial begin
		#(timeout_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
		$display("TEST FAILED");
		$finish;
	end

	task automatic idle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic host_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(negedge clk_sys);
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic set_layout(input logic [7:0] mode0, input logic [7:0] mode1);
		host_write(cfg_index_mode, 25'd0, mode0);
		host_write(cfg_index_mode, 25'd1, mode1);
	endtask

	task automatic key_event(input logic [8:0] code, input logic down);
		@(negedge clk_sys);
		ps2_key = {~ps2_key[10], down, code};
	endtask

	// Mostly low set 2 codes, so control and mahjong keys come up often
	function automatic logic [8:0] random_code(input logic [31:0] r);
		case (r[3:0])
			4'd0: return key_code_start1;
			4'd1: return key_code_start2;
			4'd2: return key_code_coin1;
			4'd3: return key_code_coin2;
			4'd4: return key_code_test;
			4'd5: return key_code_service;
			4'd6: return key_code_mj_last;
			4'd7: return {2'b11, r[10:4]}; // E0 codes nobody decodes
			default: return {2'b00, r[10:4]};
		endcase
	endfunction

	initial begin
		rst_n        = 1'b0;
		ioctl_wr     = 1'b0;
		ioctl_index  = '0;
		ioctl_addr   = '0;
		ioctl_dout   = '0;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		svc_sw       = 1'b0;
		test_sw      = 1'b0;
		osd_open     = 1'b0;
		pause_on_osd = 1'b0;
		mux_clock    = 1'b0;
		rgb_in       = '0;
		test_num     = 0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		test_num = 1; // Valid and bogus index and address pairs
		for (int i = 0; i < n_cfg; i++) begin
			rnd = $random(seed);
			host_write(rnd[2] ? cfg_index_dsw : (rnd[3] ? cfg_index_mode : rnd[31:24]),
				rnd[4] ? {23'd0, rnd[6:5]} : rnd[24:0], rnd[15:8]);
		end

		test_num = 2;
		set_layout(8'h00, 8'h00);
		for (int i = 0; i < n_std; i++) begin
			if (i == n_std / 2)
				set_layout(8'h80, 8'h00); // Buttons 1 and 2 swapped
			@(negedge clk_sys);
			rnd     = $random(seed);
			joy1    = rnd[15:0];
			joy2    = rnd[31:16];
			rnd     = $random(seed);
			svc_sw  = rnd[0];
			test_sw = rnd[1];
		end

		test_num = 3;
		set_layout(8'h00, 8'h00);
		joy1    = '0;
		joy2    = '0;
		svc_sw  = 1'b0;
		test_sw = 1'b0;
		for (int i = 0; i < n_ps2; i++) begin
			rnd = $random(seed);
			key_event(random_code(rnd >> 16), rnd[9]);
			idle(int'(rnd[13:12]));
		end

		test_num = 4;
		set_layout(8'h08, 8'h00);
		for (int i = 0; i < n_dual; i++) begin
			@(negedge clk_sys);
			rnd  = $random(seed);
			joy1 = rnd[15:0];
			joy2 = rnd[31:16];
		end

		test_num = 5;
		joy2 = '0;
		set_layout(8'h00, quirk_dakkochan);
		for (int i = 0; i < n_mj; i++) begin
			@(negedge clk_sys);
			rnd       = $random(seed);
			mux_clock = rnd[0];
			joy1      = {5'd0, rnd[17:16], 2'b00, rnd[20:18], 4'd0}; // Starts and buttons
			if (rnd[3:1] == 3'd0)
				ps2_key = {~ps2_key[10], rnd[9], random_code(rnd >> 21)};
		end

		test_num = 6;
		mux_clock = 1'b0;
		set_layout(8'h00, 8'h00);
		for (int i = 0; i < n_pause; i++) begin
			@(negedge clk_sys);
			rnd          = $random(seed);
			joy1         = {3'b000, rnd[3:0] == 4'd0, 12'd0};
			osd_open     = rnd[4] & rnd[5];
			pause_on_osd = rnd[6];
			rgb_in       = rnd[27:16];
		end
		osd_open = 1'b0;
		// Two presses, so one of the holds is spent paused
		for (int h = 0; h < 2; h++) begin
			@(negedge clk_sys);
			joy1 = 16'h1000;
			@(negedge clk_sys);
			joy1 = 16'h0000;
			repeat (hold_cycles) begin
				@(negedge clk_sys);
				rnd    = $random(seed);
				rgb_in = rnd[11:0];
			end
		end

		@(negedge clk_sys);
		test_num = 0;
		@(posedge clk_sys);
		#1;
		if (err_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== test/input_checker.sv ====
/*
 * Scoreboard for the arcade input path. A cycle model built from the port
 * rules runs beside the DUT and every output is compared on the falling
 * clock edge. Prints one line per test and a closing count line.
 */
`timescale 1ns/1ps

module input_checker import arcade_input_pkg::*; #(
	parameter logic [31:0] DIM_DELAY = 32'd200
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  int                test_num,
	input  logic              ioctl_wr,
	input  logic [7:0]        ioctl_index,
	input  logic [24:0]       ioctl_addr,
	input  logic [7:0]        ioctl_dout,
	input  logic [10:0]       ps2_key,
	input  logic [joy_w-1:0]  joy1,
	input  logic [joy_w-1:0]  joy2,
	input  logic              svc_sw,
	input  logic              test_sw,
	input  logic              osd_open,
	input  logic              pause_on_osd,
	input  logic              mux_clock,
	input  logic [rgb_w-1:0]  rgb_in,
	input  logic [port_w-1:0] inp0,
	input  logic [port_w-1:0] inp1,
	input  logic [port_w-1:0] inp2,
	input  logic [7:0]        dsw0,
	input  logic [7:0]        dsw1,
	input  logic              pause,
	input  logic [rgb_w-1:0]  rgb_out,
	output int                err_count
);

	logic [7:0]  m_mode0;
	logic [7:0]  m_mode1;
	logic [7:0]  m_dsw0;
	logic [7:0]  m_dsw1;
	logic        m_tog;
	logic [5:0]  m_keys;         // start1, start2, coin1, coin2, test, service from bit 0
	logic [4:0]  m_mj [mj_rows];
	logic [3:0]  c_dir;          // Stick bits right, left, down, up from bit 0
	logic [3:0]  c_ls;
	logic [3:0]  c_rs;
	logic [2:0]  c_trig;
	logic        c_s1;
	logic        c_s2;
	logic        c_c1;
	logic        c_c2;
	logic        c_svc;
	logic        c_tst;
	logic        c_pb;
	logic        m_mq;
	logic [2:0]  m_row;
	logic        m_pbq;
	logic        m_ptog;
	logic [31:0] m_dcnt;
	logic [7:0]  exp0;
	logic [7:0]  exp1;
	logic [7:0]  exp2;
	logic        exp_pause;
	logic [11:0] exp_rgb;
	logic        armed;
	int          errors = 0;
	int          total_checks = 0;
	int          test_checks = 0;
	int          test_errors = 0;
	int          last_test = 0;

	assign err_count = errors;

	// Port order left, right, up, down
	function automatic logic [3:0] lrud(input logic [3:0] s);
		return {s[1], s[0], s[3], s[2]};
	endfunction

	// 0 to 5 for the control keys, 10 + row * 5 + col for the mahjong panel
	function automatic int key_slot(input logic [8:0] code);
		case (code)
			key_code_start1:   return 0;
			key_code_start2:   return 1;
			key_code_coin1:    return 2;
			key_code_coin2:    return 3;
			key_code_test:     return 4;
			key_code_service:  return 5;
			key_code_mj_kan:   return 10;
			key_code_mj_reach: return 11;
			key_code_mj_ron:   return 12;
			key_code_mj_t:     return 15;
			key_code_mj_u:     return 16;
			key_code_mj_o:     return 17;
			key_code_mj_p:     return 18;
			key_code_mj_a:     return 20;
			key_code_mj_b:     return 21;
			key_code_mj_c:     return 22;
			key_code_mj_d:     return 23;
			key_code_mj_last:  return 24;
			key_code_mj_e:     return 25;
			key_code_mj_f:     return 26;
			key_code_mj_g:     return 27;
			key_code_mj_h:     return 28;
			key_code_mj_i:     return 30;
			key_code_mj_j:     return 31;
			key_code_mj_k:     return 32;
			key_code_mj_l:     return 33;
			key_code_mj_m:     return 35;
			key_code_mj_n:     return 36;
			key_code_mj_chi:   return 37;
			key_code_mj_pon:   return 38;
			key_code_mj_flip:  return 39;
			key_code_mj_bet:   return 41;
			default:           return -1; // Reset key never reaches a port
		endcase
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "config writes";
			2: return "standard layout";
			3: return "keyboard keys";
			4: return "dual-stick layout";
			5: return "mahjong scan";
			6: return "pause and dim";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input logic [15:0] got, input logic [15:0] want);
		total_checks++;
		test_checks++;
		if (got !== want) begin
			errors++;
			test_errors++;
			$display("ERROR at %0t ns: %s is %h, model expects %h", $time, what, got, want);
		end
	endtask

	////////////////////////////////////////
	// Cycle model, back of the pipe first

	always @(posedge clk_sys) begin : model
		logic [joy_w-1:0] j;
		logic [2:0]       nrow;
		logic [2:0]       trig;
		logic [4:0]       row_keys;
		logic             ptog_n;
		int               slot;
		if (!rst_n) begin
			m_mode0   = '0;
			m_mode1   = '0;
			m_dsw0    = '0;
			m_dsw1    = '0;
			m_tog     = ps2_key[10];
			m_keys    = '0;
			m_mj      = '{default: '0};
			{c_dir, c_ls, c_rs, c_trig} = '0;
			{c_s1, c_s2, c_c1, c_c2, c_svc, c_tst, c_pb} = '0;
			m_mq      = 1'b0;
			m_row     = 3'd0;
			m_pbq     = 1'b0;
			m_ptog    = 1'b0;
			m_dcnt    = '0;
			exp0      = 8'hff;
			exp1      = 8'hff;
			exp2      = 8'hff;
			exp_pause = 1'b0;
		end else begin
			// Pause and dimming
			exp_rgb   = (m_dcnt == DIM_DELAY) ? ((rgb_in >> 1) & 12'h777) : rgb_in;
			ptog_n    = m_ptog ^ (c_pb & ~m_pbq);
			exp_pause = ptog_n | (osd_open & pause_on_osd);
			if (!m_ptog)
				m_dcnt = '0;
			else if (m_dcnt < DIM_DELAY)
				m_dcnt = m_dcnt + 32'd1;
			m_ptog = ptog_n;
			m_pbq  = c_pb;

			// Ports, the new mahjong row shows right away
			nrow = m_row;
			if (mux_clock && !m_mq)
				nrow = (m_row == 3'd6) ? 3'd0 : m_row + 3'd1;
			m_mq     = mux_clock;
			m_row    = nrow;
			row_keys = m_mj[nrow];
			if (nrow == 3'd6)
				row_keys[0] = c_s1 | c_s2;
			trig = m_mode0[7] ? {c_trig[2], c_trig[0], c_trig[1]} : c_trig;
			if (m_mode0[3]) begin
				exp0 = ~{lrud(c_ls), lrud(c_rs)};
				exp1 = exp0;
				exp2 = ~{c_trig[0], c_trig[0], c_s2, c_s1, 2'b00, c_c2, c_c1};
			end else if (m_mode1 == quirk_dakkochan) begin
				exp0 = {3'b111, ~row_keys};
				exp1 = 8'd1 << nrow;
				exp2 = ~{c_trig[0], c_trig[0], 2'b00, c_svc, c_tst, c_c2, c_c1};
			end else begin
				exp0 = ~{lrud(c_dir), 1'b0, trig};
				exp1 = exp0;
				exp2 = ~{2'b00, c_s2, c_s1, c_svc, c_tst, c_c2, c_c1};
			end

			// Merged controls
			j      = joy1 | joy2;
			c_dir  = j[3:0];
			c_ls   = joy1[3:0];
			c_rs   = joy1[7:4] | joy2[3:0];
			c_trig = j[6:4];
			c_s1   = joy1[9] | joy2[10] | m_keys[0];
			c_s2   = joy1[10] | joy2[9] | m_keys[1];
			c_c1   = joy1[11] | m_keys[2];
			c_c2   = joy2[11] | m_keys[3];
			c_tst  = test_sw | m_keys[4];
			c_svc  = svc_sw | m_keys[5];
			c_pb   = j[12];

			// Keyboard
			if (ps2_key[10] != m_tog) begin
				slot = key_slot(ps2_key[8:0]);
				if (slot >= 0 && slot < 6)
					m_keys[3'(slot)] = ps2_key[9];
				else if (slot >= 10)
					m_mj[3'((slot - 10) / 5)][3'((slot - 10) % 5)] = ps2_key[9];
			end
			m_tog = ps2_key[10];

			// Host writes, mode bytes 2 and 3 go nowhere
			if (ioctl_wr && ioctl_index == cfg_index_mode && ioctl_addr == 25'd0)
				m_mode0 = ioctl_dout;
			if (ioctl_wr && ioctl_index == cfg_index_mode && ioctl_addr == 25'd1)
				m_mode1 = ioctl_dout;
			if (ioctl_wr && ioctl_index == cfg_index_dsw && ioctl_addr == 25'd0)
				m_dsw0 = ioctl_dout;
			if (ioctl_wr && ioctl_index == cfg_index_dsw && ioctl_addr == 25'd1)
				m_dsw1 = ioctl_dout;
		end
	end

	always @(posedge clk_sys) armed <= rst_n && (test_num > 0);

	always @(negedge clk_sys) begin
		if (armed) begin
			compare("inp0", {8'h00, inp0}, {8'h00, exp0});
			compare("inp1", {8'h00, inp1}, {8'h00, exp1});
			compare("inp2", {8'h00, inp2}, {8'h00, exp2});
			compare("dsw0", {8'h00, dsw0}, {8'h00, m_dsw0});
			compare("dsw1", {8'h00, dsw1}, {8'h00, m_dsw1});
			compare("pause", {15'd0, pause}, {15'd0, exp_pause});
			compare("rgb_out", {4'h0, rgb_out}, {4'h0, exp_rgb});
		end
	end

	// Report on the rising edge, when counts and test number are settled
	always @(posedge clk_sys) begin
		if (test_num != last_test) begin
			if (last_test > 0)
				$display("Test %0d (%s): %0d checks, %0d errors", last_test,
					test_name(last_test), test_checks, test_errors);
			if (test_num == 0 && last_test > 0)
				$display("Totals: %0d checks, %0d errors", total_checks, errors);
			last_test   = test_num;
			test_checks = 0;
			test_errors = 0;
		end
	end

endmodule

// ==== verilog.f ====
hw/arcade_input_pkg.sv
hw/input_ifs.sv
hw/host_config_loader.sv
hw/ps2_key_decoder.sv
hw/control_merge.sv
hw/input_port_mux.sv
hw/pause_dimmer.sv
hw/arcade_inputs_top.sv
test/input_checker.sv
test/arcade_inputs_tb.sv
